/* project.f */
common/rvPkg.sv
verilog/controlUnit.sv
verilog/immGen.sv
verilog/alu.sv
verilog/regFile.sv
core/coreFsm.sv
core/rvCore.sv
tests/clockGen.sv
tests/memModel.sv
tests/coreTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module coreTb -f project.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/coreTb.sv */
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int nProg      = 7;
    localparam int cycleLimit = nProg * (16 * 20 + 40);

    logic                   clk;
    logic                   rstN;
    logic                   resetReq;
    rvPkg::busReqT          busReq;
    logic                   req;
    logic                   halted;
    logic [rvPkg::xlen-1:0] rdata;
    logic                   ack;

    string       names [nProg];
    logic [31:0] progs [nProg][16];
    int          expCount [nProg];
    logic [31:0] expAddr [nProg][4];
    logic [31:0] expData [nProg][4];
    logic [31:0] storeAddr [$];
    logic [31:0] storeData [$];
    logic        reqPrev;
    int          cycles;

    clockGen clocks (
        .resetReq (resetReq),
        .clk      (clk),
        .rstN     (rstN)
    );

    memModel mem (
        .clk    (clk),
        .rstN   (rstN),
        .busReq (busReq),
        .req    (req),
        .rdata  (rdata),
        .ack    (ack)
    );

    rvCore UUT (
        .clk    (clk),
        .rstN   (rstN),
        .rdata  (rdata),
        .ack    (ack),
        .busReq (busReq),
        .req    (req),
        .halted (halted)
    );

    function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::opReg};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
    endfunction

    function automatic logic [31:0] bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::opBranch};
    endfunction

    function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opJal};
    endfunction

    function automatic logic [31:0] fillWord(int i);
        return (32'(i) * 32'h9E3779B1) ^ 32'h5A5A5A5A;
    endfunction

    function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Something failed");
            $display("error %s expected %h actual %h", what, expected, actual);
            $fatal(1);
        end
    endtask

    task automatic expectStore(int p, logic [31:0] a, logic [31:0] d);
        expAddr[p][expCount[p]] = a;
        expData[p][expCount[p]] = d;
        expCount[p] = expCount[p] + 1;
    endtask

    // six branches, each skipping one marker add when taken
    task automatic branchProgram(int p, string nm, logic [11:0] a, logic [11:0] b);
        logic [2:0]  f3s [6];
        logic [31:0] marker;
        f3s    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        marker = '0;
        names[p] = nm;
        progs[p][0] = iType(a, 5'd0, 3'd0, 5'd1, rvPkg::opImm);
        progs[p][1] = iType(b, 5'd0, 3'd0, 5'd2, rvPkg::opImm);
        for (int k = 0; k < 6; k++) begin
            progs[p][2 + 2 * k] = bType(13'd8, 5'd2, 5'd1, f3s[k]);
            progs[p][3 + 2 * k] = iType(12'(1 << k), 5'd10, 3'd0, 5'd10, rvPkg::opImm);
            if (!branchTaken(f3s[k], {{20{a[11]}}, a}, {{20{b[11]}}, b})) begin
                marker = marker + 32'(1 << k);
            end
        end
        progs[p][14] = sType(12'h100, 5'd10, 5'd0);
        expectStore(p, 32'h100, marker);
    endtask

    task automatic buildPrograms();
        logic [31:0] v;
        for (int p = 0; p < nProg; p++) begin
            expCount[p] = 0;
            for (int i = 0; i < 16; i++) begin
                progs[p][i] = '0;
            end
        end

        names[0] = "arith";
        progs[0][0]  = iType(12'hFFB, 5'd0, 3'd0, 5'd1, rvPkg::opImm);
        progs[0][1]  = iType(12'd3, 5'd0, 3'd0, 5'd2, rvPkg::opImm);
        progs[0][2]  = rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd3);
        progs[0][3]  = rType(7'h00, 5'd2, 5'd1, 3'd2, 5'd4);
        progs[0][4]  = rType(7'h00, 5'd2, 5'd1, 3'd3, 5'd5);
        progs[0][5]  = rType(7'h00, 5'd2, 5'd1, 3'd4, 5'd8);
        progs[0][6]  = iType(12'h0F0, 5'd8, 3'd7, 5'd9, rvPkg::opImm);
        progs[0][7]  = rType(7'h00, 5'd4, 5'd9, 3'd6, 5'd9);
        progs[0][8]  = sType(12'h100, 5'd3, 5'd0);
        progs[0][9]  = sType(12'h104, 5'd4, 5'd0);
        progs[0][10] = sType(12'h108, 5'd5, 5'd0);
        progs[0][11] = sType(12'h10C, 5'd9, 5'd0);
        expectStore(0, 32'h100, 32'hFFFFFFFB - 32'd3);
        expectStore(0, 32'h104, 32'd1);
        expectStore(0, 32'h108, 32'd0);
        expectStore(0, 32'h10C, ((32'hFFFFFFFB ^ 32'd3) & 32'hF0) | 32'd1);

        // shifts of 0x800000f0
        names[1] = "shift";
        v = 32'h800000F0;
        progs[1][0]  = uType(20'h80000, 5'd1, rvPkg::opLui);
        progs[1][1]  = iType(12'h0F0, 5'd1, 3'd0, 5'd1, rvPkg::opImm);
        progs[1][2]  = iType(12'd4, 5'd0, 3'd0, 5'd2, rvPkg::opImm);
        progs[1][3]  = rType(7'h00, 5'd2, 5'd1, 3'd1, 5'd3);
        progs[1][4]  = rType(7'h00, 5'd2, 5'd1, 3'd5, 5'd4);
        progs[1][5]  = rType(7'h20, 5'd2, 5'd1, 3'd5, 5'd5);
        progs[1][6]  = iType({7'h20, 5'd8}, 5'd1, 3'd5, 5'd6, rvPkg::opImm);
        progs[1][7]  = iType({7'h00, 5'd8}, 5'd1, 3'd5, 5'd7, rvPkg::opImm);
        progs[1][8]  = iType(12'd1, 5'd1, 3'd1, 5'd8, rvPkg::opImm);
        progs[1][9]  = rType(7'h00, 5'd8, 5'd6, 3'd4, 5'd9);
        progs[1][10] = rType(7'h00, 5'd7, 5'd9, 3'd4, 5'd9);
        progs[1][11] = sType(12'h100, 5'd3, 5'd0);
        progs[1][12] = sType(12'h104, 5'd4, 5'd0);
        progs[1][13] = sType(12'h108, 5'd5, 5'd0);
        progs[1][14] = sType(12'h10C, 5'd9, 5'd0);
        expectStore(1, 32'h100, v << 4);
        expectStore(1, 32'h104, v >> 4);
        expectStore(1, 32'h108, 32'($signed(v) >>> 4));
        expectStore(1, 32'h10C, 32'($signed(v) >>> 8) ^ (v << 1) ^ (v >> 8));

        names[2] = "load";
        progs[2][0] = iType(12'h123, 5'd0, 3'd0, 5'd1, rvPkg::opImm);
        progs[2][1] = sType(12'h100, 5'd1, 5'd0);
        progs[2][2] = iType(12'h100, 5'd0, 3'd2, 5'd2, rvPkg::opLoad);
        progs[2][3] = iType(12'd5, 5'd2, 3'd0, 5'd3, rvPkg::opImm);
        progs[2][4] = sType(12'h104, 5'd3, 5'd0);
        progs[2][5] = iType(12'h180, 5'd0, 3'd2, 5'd4, rvPkg::opLoad);
        progs[2][6] = rType(7'h00, 5'd3, 5'd4, 3'd0, 5'd5);
        progs[2][7] = sType(12'h108, 5'd5, 5'd0);
        expectStore(2, 32'h100, 32'h123);
        expectStore(2, 32'h104, 32'h128);
        expectStore(2, 32'h108, fillWord(96) + 32'h128);

        branchProgram(3, "branch -2,3", 12'hFFE, 12'd3);
        branchProgram(4, "branch 3,3", 12'd3, 12'd3);
        branchProgram(5, "branch 3,-2", 12'd3, 12'hFFE);

        // skipped slots would overwrite the link registers
        names[6] = "jump";
        progs[6][0] = uType(20'h12345, 5'd1, rvPkg::opLui);
        progs[6][1] = uType(20'h00001, 5'd2, rvPkg::opAuipc);
        progs[6][2] = jType(21'd8, 5'd3);
        progs[6][3] = iType(12'd99, 5'd0, 3'd0, 5'd3, rvPkg::opImm);
        progs[6][4] = iType(12'h019, 5'd0, 3'd0, 5'd4, rvPkg::opJalr);
        progs[6][5] = iType(12'd0, 5'd0, 3'd0, 5'd4, rvPkg::opImm);
        progs[6][6] = sType(12'h100, 5'd1, 5'd0);
        progs[6][7] = sType(12'h104, 5'd2, 5'd0);
        progs[6][8] = sType(12'h108, 5'd3, 5'd0);
        progs[6][9] = sType(12'h10C, 5'd4, 5'd0);
        expectStore(6, 32'h100, 32'h12345000);
        expectStore(6, 32'h104, 32'd4 + 32'h1000);
        expectStore(6, 32'h108, 32'd8 + 32'd4);
        expectStore(6, 32'h10C, 32'd16 + 32'd4);
    endtask

    task automatic loadMemory(int p);
        for (int i = 0; i < 128; i++) begin
            mem.words[i] = (i < 16) ? progs[p][i] : fillWord(i);
        end
    endtask

    // a store shows up as a fresh request with we set
    always @(negedge clk) begin
        if (req && !reqPrev && busReq.we) begin
            storeAddr.push_back(busReq.addr);
            storeData.push_back(busReq.wdata);
        end
        reqPrev = req;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Something failed");
            $display("timeout: the programs did not all halt within %0d cycles", cycleLimit);
            $fatal(1);
        end
    end

    initial begin
        resetReq = 1'b0;
        reqPrev  = 1'b0;
        cycles   = 0;
        buildPrograms();
        for (int p = 0; p < nProg; p++) begin
            loadMemory(p);
            storeAddr.delete();
            storeData.delete();
            @(negedge clk);
            resetReq = 1'b1;
            @(negedge clk);
            resetReq = 1'b0;
            @(posedge clk);
            while (!rstN) begin
                @(posedge clk);
            end
            @(negedge clk);
            while (!halted) begin
                @(negedge clk);
            end
            repeat (20) begin
                @(negedge clk);
                checkValue({names[p], " req after halt"}, 32'd0, 32'(req));
            end
            checkValue({names[p], " store count"}, 32'(expCount[p]), 32'(storeAddr.size()));
            for (int s = 0; s < expCount[p]; s++) begin
                checkValue({names[p], " store addr"}, expAddr[p][s], storeAddr[s]);
                checkValue({names[p], " store data"}, expData[p][s], storeData[s]);
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

/* tests/memModel.sv */
module memModel (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvPkg::busReqT          busReq,
    input  logic                   req,
    output logic [rvPkg::xlen-1:0] rdata,
    output logic                   ack
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] words [128];
    logic [31:0] lfsr;
    logic        busy;
    logic [1:0]  waitCnt;
    logic [6:0]  idx;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    initial begin
        lfsr    = 32'h2c1b;
        busy    = 1'b0;
        waitCnt = 2'd0;
        ack     = 1'b0;
        rdata   = '0;
    end

    always @(negedge clk) begin
        idx = busReq.addr[8:2];
        if (!rstN) begin
            ack  <= 1'b0;
            busy = 1'b0;
        end else if (req && !ack) begin
            if (!busy) begin
                // two bits of delay, one step per bit
                busy       = 1'b1;
                waitCnt[0] = lfsr[0];
                lfsr       = lfsrStep(lfsr);
                waitCnt[1] = lfsr[0];
                lfsr       = lfsrStep(lfsr);
            end
            if (waitCnt == 2'd0) begin
                if (busReq.we) begin
                    words[idx] = busReq.wdata;
                end else begin
                    rdata <= words[idx];
                end
                ack  <= 1'b1;
                busy = 1'b0;
            end else begin
                waitCnt = waitCnt - 2'd1;
            end
        end else if (!req && ack) begin
            ack <= 1'b0;
        end
    end

endmodule

/* tests/clockGen.sv */
module clockGen (
    input  logic resetReq,
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    int   cnt;
    logic load;

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        cnt  = 4;
        load = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk) begin
        load <= resetReq;
    end

    // reset held low for four rising edges after each request
    always @(negedge clk) begin
        if (load) begin
            cnt = 4;
        end
        if (cnt > 0) begin
            rstN <= 1'b0;
            cnt = cnt - 1;
        end else begin
            rstN <= 1'b1;
        end
    end

endmodule

/* core/rvCore.sv */
module rvCore (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [rvPkg::xlen-1:0] rdata,
    input  logic                   ack,
    output rvPkg::busReqT          busReq,
    output logic                   req,
    output logic                   halted
);

    rvPkg::ctrlT            ctrl;
    logic                   haltInstr;
    logic [rvPkg::xlen-1:0] instr;
    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] imm;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] aluA;
    logic [rvPkg::xlen-1:0] aluB;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] wbData;
    logic                   regWe;
    logic [4:0]             rs1Idx;

    coreFsm fsm (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .haltInstr (haltInstr),
        .imm       (imm),
        .aluResult (aluResult),
        .rs2Data   (rs2Data),
        .rdata     (rdata),
        .ack       (ack),
        .instr     (instr),
        .pc        (pc),
        .busReq    (busReq),
        .req       (req),
        .regWe     (regWe),
        .wbData    (wbData),
        .halted    (halted)
    );

    controlUnit decoder (
        .instr     (instr),
        .ctrl      (ctrl),
        .haltInstr (haltInstr)
    );

    immGen immUnit (
        .instr  (instr),
        .immFmt (ctrl.immFmt),
        .imm    (imm)
    );

    // lui has immediate bits in the rs1 field, so read x0 instead
    assign rs1Idx = (instr[6:0] == rvPkg::opLui) ? 5'd0 : instr[19:15];

    regFile regs (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (rs1Idx),
        .rs2    (instr[24:20]),
        .rd     (instr[11:7]),
        .we     (regWe),
        .wdata  (wbData),
        .rdata1 (rs1Data),
        .rdata2 (rs2Data)
    );

    assign aluA = (ctrl.aSrc == rvPkg::aSrcPc) ? pc : rs1Data;

    always_comb begin
        case (ctrl.bSrc)
            rvPkg::bSrcImm:  aluB = imm;
            rvPkg::bSrcFour: aluB = 32'd4;
            default:         aluB = rs2Data;
        endcase
    end

    alu aluUnit (
        .a      (aluA),
        .b      (aluB),
        .aluOp  (ctrl.aluOp),
        .result (aluResult)
    );

endmodule

/* core/coreFsm.sv */
module coreFsm (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvPkg::ctrlT            ctrl,
    input  logic                   haltInstr,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [rvPkg::xlen-1:0] aluResult,
    input  logic [rvPkg::xlen-1:0] rs2Data,
    input  logic [rvPkg::xlen-1:0] rdata,
    input  logic                   ack,
    output logic [rvPkg::xlen-1:0] instr,
    output logic [rvPkg::xlen-1:0] pc,
    output rvPkg::busReqT          busReq,
    output logic                   req,
    output logic                   regWe,
    output logic [rvPkg::xlen-1:0] wbData,
    output logic                   halted
);

    typedef enum logic [2:0] {
        sFetchReq,
        sFetchRel,
        sExec,
        sMemReq,
        sMemRel,
        sWb,
        sHalt
    } stateT;

    stateT                  state;
    logic [rvPkg::xlen-1:0] loadData;
    logic [rvPkg::xlen-1:0] pcPlus4;
    logic [rvPkg::xlen-1:0] pcPlusImm;
    logic [rvPkg::xlen-1:0] nextPc;
    logic                   memPhase;
    logic                   isJalr;
    logic                   cond;
    logic                   taken;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sFetchReq;
            req   <= 1'b0;
            pc    <= '0;
        end else begin
            case (state)
                sFetchReq, sMemReq: begin
                    // raise only after the previous ack has dropped
                    if (req && ack) begin
                        req   <= 1'b0;
                        state <= (state == sFetchReq) ? sFetchRel : sMemRel;
                    end else if (!req && !ack) begin
                        req <= 1'b1;
                    end
                end
                sFetchRel: begin
                    if (!ack) begin
                        state <= sExec;
                    end
                end
                sExec: begin
                    if (haltInstr) begin
                        state <= sHalt;
                    end else if (ctrl.memRead || ctrl.memWrite) begin
                        state <= sMemReq;
                    end else begin
                        state <= sWb;
                    end
                end
                sMemRel: begin
                    if (!ack) begin
                        state <= sWb;
                    end
                end
                sWb: begin
                    pc    <= nextPc;
                    state <= sFetchReq;
                end
                sHalt: begin
                    state <= sHalt;
                end
                default: begin
                    state <= sFetchReq;
                end
            endcase
        end
    end

    // instruction and load data captured while ack is high
    always_ff @(posedge clk) begin
        if (req && ack && (state == sFetchReq)) begin
            instr <= rdata;
        end
        if (req && ack && (state == sMemReq)) begin
            loadData <= rdata;
        end
    end

    // branch decision from the compare result
    assign cond  = instr[14] ? aluResult[0] : (aluResult == '0);
    assign taken = ctrl.branch & (cond ^ instr[12]);

    assign isJalr    = (instr[6:0] == rvPkg::opJalr);
    assign pcPlus4   = pc + 32'd4;
    assign pcPlusImm = pc + imm;

    always_comb begin
        if (taken || (ctrl.jump && !isJalr)) begin
            nextPc = pcPlusImm;
        end else if (isJalr) begin
            nextPc = {aluResult[rvPkg::xlen-1:1], 1'b0};
        end else begin
            nextPc = pcPlus4;
        end
    end

    // jalr uses the alu for its target, so its link is pc + 4
    always_comb begin
        if (ctrl.memRead) begin
            wbData = loadData;
        end else if (isJalr) begin
            wbData = pcPlus4;
        end else begin
            wbData = aluResult;
        end
    end

    assign regWe = (state == sWb) & ctrl.regWrite;

    // ir and registers do not change during a transfer, so the request is stable
    assign memPhase      = (state == sMemReq) || (state == sMemRel);
    assign busReq.addr   = memPhase ? aluResult : pc;
    assign busReq.wdata  = rs2Data;
    assign busReq.we     = memPhase & ctrl.memWrite;

    assign halted = (state == sHalt);

endmodule

/* verilog/regFile.sv */
module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  logic [4:0]             rd,
    input  logic                   we,
    input  logic [rvPkg::xlen-1:0] wdata,
    output logic [rvPkg::xlen-1:0] rdata1,
    output logic [rvPkg::xlen-1:0] rdata2
);

    logic [rvPkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* verilog/alu.sv */
module alu (
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    input  rvPkg::aluOpT           aluOp,
    output logic [rvPkg::xlen-1:0] result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = b[4:0];
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd: begin
                result = a + b;
            end
            rvPkg::aluSub: begin
                result = a - b;
            end
            rvPkg::aluSll: begin
                result = a << shamt;
            end
            rvPkg::aluSlt: begin
                result = {31'b0, lessSigned};
            end
            rvPkg::aluSltu: begin
                result = {31'b0, lessUnsigned};
            end
            rvPkg::aluXor: begin
                result = a ^ b;
            end
            rvPkg::aluSrl: begin
                result = a >> shamt;
            end
            rvPkg::aluSra: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            rvPkg::aluOr: begin
                result = a | b;
            end
            default: begin
                result = a & b;
            end
        endcase
    end

endmodule

/* verilog/immGen.sv */
module immGen (
    input  logic [rvPkg::xlen-1:0] instr,
    input  rvPkg::immFmtT          immFmt,
    output logic [rvPkg::xlen-1:0] imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFmt)
            rvPkg::immS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            rvPkg::immB: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvPkg::immU: begin
                imm = {instr[31:12], 12'b0};
            end
            rvPkg::immJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                // I format
                imm = {{20{sign}}, instr[31:20]};
            end
        endcase
    end

endmodule

/* verilog/controlUnit.sv */
module controlUnit (
    input  logic [rvPkg::xlen-1:0] instr,
    output rvPkg::ctrlT            ctrl,
    output logic                   haltInstr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7;
    logic       isImm, isReg, isJal, isJalr, isStore, isLoad, isBranch, isAuipc, isLui;
    rvPkg::aluOpT riSel;
    rvPkg::aluOpT bSel;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[30];

    // opcode classes, all compared in parallel
    assign isImm    = (opcode == rvPkg::opImm);
    assign isReg    = (opcode == rvPkg::opReg);
    assign isJal    = (opcode == rvPkg::opJal);
    assign isJalr   = (opcode == rvPkg::opJalr);
    assign isStore  = (opcode == rvPkg::opStore);
    assign isLoad   = (opcode == rvPkg::opLoad);
    assign isBranch = (opcode == rvPkg::opBranch);
    assign isAuipc  = (opcode == rvPkg::opAuipc);
    assign isLui    = (opcode == rvPkg::opLui);

    // register and immediate ALU ops
    always_comb begin
        case (funct3)
            3'b000:  riSel = (isReg && funct7) ? rvPkg::aluSub : rvPkg::aluAdd;
            3'b001:  riSel = rvPkg::aluSll;
            3'b010:  riSel = rvPkg::aluSlt;
            3'b011:  riSel = rvPkg::aluSltu;
            3'b100:  riSel = rvPkg::aluXor;
            3'b101:  riSel = funct7 ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  riSel = rvPkg::aluOr;
            default: riSel = rvPkg::aluAnd;
        endcase
    end

    // branch compares: eq/ne -> sub, lt/ge -> slt, ltu/geu -> sltu
    always_comb begin
        if (funct3[2] & funct3[1]) begin
            bSel = rvPkg::aluSltu;
        end else if (funct3[2] ^ funct3[1]) begin
            bSel = rvPkg::aluSlt;
        end else begin
            bSel = rvPkg::aluSub;
        end
    end

    always_comb begin
        if (isLui || isAuipc) begin
            ctrl.immFmt = rvPkg::immU;
        end else if (isBranch) begin
            ctrl.immFmt = rvPkg::immB;
        end else if (isStore) begin
            ctrl.immFmt = rvPkg::immS;
        end else if (isJal) begin
            ctrl.immFmt = rvPkg::immJ;
        end else begin
            ctrl.immFmt = rvPkg::immI;
        end

        ctrl.regWrite = isImm | isReg | isJal | isJalr | isLoad | isAuipc | isLui;
        ctrl.memWrite = isStore;
        ctrl.memRead  = isLoad;
        ctrl.branch   = isBranch;
        ctrl.jump     = isJal | isJalr;

        ctrl.aSrc = (isAuipc || isJal) ? rvPkg::aSrcPc : rvPkg::aSrcReg;

        // jalr adds rs1 + imm for its target, link comes from pc + 4
        if (isJal) begin
            ctrl.bSrc = rvPkg::bSrcFour;
        end else if (isLui || isAuipc || isImm || isLoad || isStore || isJalr) begin
            ctrl.bSrc = rvPkg::bSrcImm;
        end else begin
            ctrl.bSrc = rvPkg::bSrcReg;
        end

        if (isBranch) begin
            ctrl.aluOp = bSel;
        end else if (isImm || isReg) begin
            ctrl.aluOp = riSel;
        end else begin
            ctrl.aluOp = rvPkg::aluAdd;
        end
    end

    assign haltInstr = (instr == '0);

endmodule

/* common/rvPkg.sv */
package rvPkg;

    localparam int xlen = 32;

    // base opcodes, instr[6:0]
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOpT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immFmtT;

    typedef enum logic {
        aSrcReg,
        aSrcPc
    } aSrcT;

    typedef enum logic [1:0] {
        bSrcReg,
        bSrcImm,
        bSrcFour
    } bSrcT;

    // decoder outputs
    typedef struct packed {
        immFmtT immFmt;
        logic   regWrite;
        logic   memWrite;
        logic   memRead;
        logic   branch;
        logic   jump;
        aSrcT   aSrc;
        bSrcT   bSrc;
        aluOpT  aluOp;
    } ctrlT;

    // one bus request, held while req is high
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            we;
    } busReqT;

endpackage
